/* Makefile */
VERILATOR ?= verilator
TOP       ?= spi_bridge_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/bridge_ifs.sv */
`timescale 1ns/1ps

// Byte stream between the pin front end and the command decoder
interface spi_byte_if;
    logic                                  frame_start;   // CS fell
    logic                                  frame_end;     // CS rose
    logic                                  frame_active;  // CS low
    logic                                  rx_valid;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] rx_byte;
    logic                                  tx_load;       // Next byte out is tx_byte
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] tx_byte;

    modport producer (
        output frame_start, frame_end, frame_active, rx_valid, rx_byte,
        input  tx_load, tx_byte
    );

    modport consumer (
        input  frame_start, frame_end, frame_active, rx_valid, rx_byte,
        output tx_load, tx_byte
    );
endinterface

// One bus request at a time, fields held until done
interface bus_req_if;
    logic                                  req;    // Single-cycle pulse
    logic [spi_bridge_pkg::ADDR_WIDTH-1:0] addr;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] wdata;
    logic                                  we;
    logic                                  done;   // Single-cycle pulse
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] rdata;  // Valid with done

    modport requester (
        output req, addr, wdata, we,
        input  done, rdata
    );

    modport responder (
        input  req, addr, wdata, we,
        output done, rdata
    );
endinterface

/* logic/spi_bridge_pkg.sv */
package spi_bridge_pkg;

    // Bus widths seen by the bridge and the memory
    localparam int ADDR_WIDTH = 20;
    localparam int DATA_WIDTH = 8;

    // Opcode in bits 7..6 of the command byte
    typedef enum logic [1:0] {
        OP_WRITE_AT  = 2'd0,  // Cmd, addr hi, addr lo, data
        OP_READ_AT   = 2'd1,  // Cmd, addr hi, addr lo
        OP_READ_NEXT = 2'd2,  // Cmd only, last address + 1
        OP_RESERVED  = 2'd3   // Rest of frame ignored
    } spi_op_e;

endpackage

/* logic/spi_bridge_top.sv */
`timescale 1ns/1ps

module spi_bridge_top #(
    parameter int MEM_ADDR_BITS = 12
) (
    input  logic clock,
    input  logic rst_i,
    input  logic spi_sck_i,
    input  logic spi_cs_ni,
    input  logic spi_pico_i,
    output logic spi_poci_o,
    output logic spi_stall_o
);
    spi_byte_if bytes_if ();
    bus_req_if  bus_if ();

    logic                                  wb_cyc;
    logic                                  wb_we;
    logic [spi_bridge_pkg::ADDR_WIDTH-1:0] wb_adr;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] wb_dat_w;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] wb_dat_r;
    logic                                  wb_ack;

    spi_sync_shifter sync0 (
        .clock      (clock),
        .rst_i      (rst_i),
        .spi_sck_i  (spi_sck_i),
        .spi_cs_ni  (spi_cs_ni),
        .spi_pico_i (spi_pico_i),
        .spi_poci_o (spi_poci_o),
        .bytes      (bytes_if.producer)
    );

    spi_cmd_engine engine0 (
        .clock   (clock),
        .rst_i   (rst_i),
        .bytes   (bytes_if.consumer),
        .bus     (bus_if.requester),
        .stall_o (spi_stall_o)
    );

    wb_cycle_master master0 (
        .clock    (clock),
        .rst_i    (rst_i),
        .bus      (bus_if.responder),
        .abort_i  (bytes_if.frame_end),   // CS rising ends any cycle
        .wb_cyc_o (wb_cyc),
        .wb_we_o  (wb_we),
        .wb_adr_o (wb_adr),
        .wb_dat_o (wb_dat_w),
        .wb_dat_i (wb_dat_r),
        .wb_ack_i (wb_ack)
    );

    sram_target #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) sram0 (
        .clock (clock),
        .rst_i (rst_i),
        .cyc_i (wb_cyc),
        .we_i  (wb_we),
        .adr_i (wb_adr),
        .dat_i (wb_dat_w),
        .dat_o (wb_dat_r),
        .ack_o (wb_ack)
    );
endmodule

/* logic/spi_cmd_engine.sv */
`timescale 1ns/1ps

module spi_cmd_engine (
    input  logic         clock,
    input  logic         rst_i,
    spi_byte_if.consumer bytes,
    bus_req_if.requester bus,
    output logic         stall_o
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_CMD,
        S_ADDR_HI,
        S_ADDR_LO,
        S_DATA,
        S_WAIT,      // Bus cycle pending
        S_DONE       // Ignore bytes until CS rises
    } state_e;

    state_e                                state_q;
    spi_bridge_pkg::spi_op_e               op;
    logic                                  byte_in;
    logic [spi_bridge_pkg::ADDR_WIDTH-1:0] addr_q;       // Last bus address
    logic [3:0]                            addr_top_q;   // Bits 19..16 from command byte
    logic [7:0]                            addr_mid_q;   // Bits 15..8
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] wdata_q;
    logic                                  we_q;
    logic                                  req_q;
    logic                                  stall_q;

    assign op      = spi_bridge_pkg::spi_op_e'(bytes.rx_byte[7:6]);
    assign byte_in = bytes.rx_valid & bytes.frame_active;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            addr_q  <= '0;
            we_q    <= 1'b0;
            req_q   <= 1'b0;
            stall_q <= 1'b0;
        end else begin
            req_q <= 1'b0;
            if (bytes.frame_end) begin
                state_q <= S_IDLE;   // Abandons any pending cycle
                stall_q <= 1'b0;
            end else if (bytes.frame_start) begin
                state_q <= S_CMD;
                stall_q <= 1'b0;
            end else begin
                case (state_q)
                    S_CMD: begin
                        if (byte_in) begin
                            case (op)
                                spi_bridge_pkg::OP_WRITE_AT: begin
                                    we_q    <= 1'b1;
                                    state_q <= S_ADDR_HI;
                                end
                                spi_bridge_pkg::OP_READ_AT: begin
                                    we_q    <= 1'b0;
                                    state_q <= S_ADDR_HI;
                                end
                                spi_bridge_pkg::OP_READ_NEXT: begin
                                    addr_q  <= addr_q + 1'b1;   // Wraps at 2^20
                                    we_q    <= 1'b0;
                                    req_q   <= 1'b1;
                                    stall_q <= 1'b1;
                                    state_q <= S_WAIT;
                                end
                                default: begin
                                    state_q <= S_DONE;
                                end
                            endcase
                        end
                    end
                    S_ADDR_HI: begin
                        if (byte_in) begin
                            state_q <= S_ADDR_LO;
                        end
                    end
                    S_ADDR_LO: begin
                        if (byte_in) begin
                            addr_q <= {addr_top_q, addr_mid_q, bytes.rx_byte};
                            if (we_q) begin
                                state_q <= S_DATA;
                            end else begin
                                req_q   <= 1'b1;
                                stall_q <= 1'b1;
                                state_q <= S_WAIT;
                            end
                        end
                    end
                    S_DATA: begin
                        if (byte_in) begin
                            req_q   <= 1'b1;
                            stall_q <= 1'b1;
                            state_q <= S_WAIT;
                        end
                    end
                    S_WAIT: begin
                        // Bytes clocked here are dropped
                        if (bus.done) begin
                            stall_q <= 1'b0;
                            state_q <= S_DONE;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (byte_in) begin
            case (state_q)
                S_CMD:     addr_top_q <= bytes.rx_byte[3:0];
                S_ADDR_HI: addr_mid_q <= bytes.rx_byte;
                S_DATA:    wdata_q    <= bytes.rx_byte;
                default: begin
                end
            endcase
        end
    end

    assign bus.req   = req_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;
    assign bus.we    = we_q;

    // Read data goes out on the host's dummy byte
    assign bytes.tx_load = (state_q == S_WAIT) & bus.done & ~we_q;
    assign bytes.tx_byte = bus.rdata;
    assign stall_o       = stall_q;
endmodule

/* logic/spi_sync_shifter.sv */
`timescale 1ns/1ps

module spi_sync_shifter (
    input  logic         clock,
    input  logic         rst_i,
    input  logic         spi_sck_i,
    input  logic         spi_cs_ni,
    input  logic         spi_pico_i,
    output logic         spi_poci_o,
    spi_byte_if.producer bytes
);
    localparam int W  = spi_bridge_pkg::DATA_WIDTH;
    localparam int CW = $clog2(W);

    logic [1:0]    sck_sync;   // Bit 1 is the second stage
    logic [1:0]    cs_sync;
    logic [1:0]    pico_sync;
    logic          sck_d;      // Previous synchronized level
    logic          cs_d;
    logic          sck_rise;
    logic          sck_fall;
    logic          cs_fall;
    logic          cs_rise;
    logic [CW-1:0] bit_cnt;
    logic          rx_valid_q;
    logic [W-1:0]  rx_shift;
    logic [W-1:0]  tx_shift;
    logic          poci_q;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            sck_sync  <= 2'b00;
            cs_sync   <= 2'b11;   // Deselected
            pico_sync <= 2'b00;
            sck_d     <= 1'b0;
            cs_d      <= 1'b1;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck_i};
            cs_sync   <= {cs_sync[0], spi_cs_ni};
            pico_sync <= {pico_sync[0], spi_pico_i};
            sck_d     <= sck_sync[1];
            cs_d      <= cs_sync[1];
        end
    end

    // SCK edges only count while selected
    assign sck_rise = sck_sync[1] & ~sck_d & ~cs_sync[1];
    assign sck_fall = ~sck_sync[1] & sck_d & ~cs_sync[1];
    assign cs_fall  = ~cs_sync[1] & cs_d;
    assign cs_rise  = cs_sync[1] & ~cs_d;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            bit_cnt    <= '0;
            rx_valid_q <= 1'b0;
            tx_shift   <= '0;
            poci_q     <= 1'b0;
        end else begin
            rx_valid_q <= 1'b0;
            if (cs_fall || cs_rise) begin
                bit_cnt  <= '0;
                tx_shift <= '0;
                poci_q   <= 1'b0;
            end else begin
                if (sck_rise) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CW'(W - 1)) begin
                        rx_valid_q <= 1'b1;   // Eighth bit in
                    end
                end
                if (bytes.tx_load) begin
                    poci_q   <= bytes.tx_byte[W-1];   // MSB ready before first rise
                    tx_shift <= {bytes.tx_byte[W-2:0], 1'b0};
                end else if (sck_fall && bit_cnt != '0) begin
                    // Falling edge that closes a byte leaves POCI alone
                    poci_q   <= tx_shift[W-1];
                    tx_shift <= {tx_shift[W-2:0], 1'b0};
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[W-2:0], pico_sync[1]};   // MSB first
        end
    end

    assign bytes.frame_start  = cs_fall;
    assign bytes.frame_end    = cs_rise;
    assign bytes.frame_active = ~cs_sync[1];
    assign bytes.rx_valid     = rx_valid_q;
    assign bytes.rx_byte      = rx_shift;
    assign spi_poci_o         = poci_q;
endmodule

/* logic/sram_target.sv */
`timescale 1ns/1ps

module sram_target #(
    parameter int MEM_ADDR_BITS = 12
) (
    input  logic                                  clock,
    input  logic                                  rst_i,
    input  logic                                  cyc_i,
    input  logic                                  we_i,
    input  logic [spi_bridge_pkg::ADDR_WIDTH-1:0] adr_i,
    input  logic [spi_bridge_pkg::DATA_WIDTH-1:0] dat_i,
    output logic [spi_bridge_pkg::DATA_WIDTH-1:0] dat_o,
    output logic                                  ack_o
);
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] mem [2**MEM_ADDR_BITS];
    logic [MEM_ADDR_BITS-1:0]              idx;
    logic                                  access;
    logic                                  ack_q;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] dat_q;

    assign idx    = adr_i[MEM_ADDR_BITS-1:0];   // Upper bits alias
    assign access = cyc_i & ~ack_q;             // Cyc still high in ack cycle

    always_ff @(posedge clock) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            if (we_i) begin
                mem[idx] <= dat_i;
            end
            dat_q <= mem[idx];
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;
endmodule

/* logic/wb_cycle_master.sv */
`timescale 1ns/1ps

module wb_cycle_master (
    input  logic                                  clock,
    input  logic                                  rst_i,
    bus_req_if.responder                          bus,
    input  logic                                  abort_i,   // Frame ended
    output logic                                  wb_cyc_o,
    output logic                                  wb_we_o,
    output logic [spi_bridge_pkg::ADDR_WIDTH-1:0] wb_adr_o,
    output logic [spi_bridge_pkg::DATA_WIDTH-1:0] wb_dat_o,
    input  logic [spi_bridge_pkg::DATA_WIDTH-1:0] wb_dat_i,
    input  logic                                  wb_ack_i
);
    logic                                  cyc_q;
    logic                                  we_q;
    logic                                  done_q;
    logic [spi_bridge_pkg::ADDR_WIDTH-1:0] adr_q;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] dat_w_q;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] dat_r_q;

    always_ff @(posedge clock) begin
        if (rst_i) begin
            cyc_q  <= 1'b0;
            we_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (abort_i) begin
                cyc_q <= 1'b0;   // No done on abort
            end else if (cyc_q && wb_ack_i) begin
                cyc_q  <= 1'b0;
                done_q <= 1'b1;
            end else if (bus.req) begin
                cyc_q <= 1'b1;
                we_q  <= bus.we;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (bus.req && !cyc_q) begin
            adr_q   <= bus.addr;
            dat_w_q <= bus.wdata;
        end
        if (cyc_q && wb_ack_i) begin
            dat_r_q <= wb_dat_i;   // Read data valid with ack
        end
    end

    assign wb_cyc_o  = cyc_q;
    assign wb_we_o   = we_q;
    assign wb_adr_o  = adr_q;
    assign wb_dat_o  = dat_w_q;
    assign bus.done  = done_q;
    assign bus.rdata = dat_r_q;
endmodule

/* tb.f */
logic/spi_bridge_pkg.sv
logic/bridge_ifs.sv
logic/spi_sync_shifter.sv
logic/spi_cmd_engine.sv
logic/wb_cycle_master.sv
logic/sram_target.sv
logic/spi_bridge_top.sv
test/spi_bridge_tb.sv

/* test/spi_bridge_tb.sv */
`timescale 1ns/1ps

module spi_bridge_tb;
    localparam int MEM_BITS       = 12;
    localparam int MODEL_SIZE     = 2**MEM_BITS;
    localparam int HALF_SCK       = 5;     // Clocks per SCK half period
    localparam int NUM_FRAMES     = 67;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 400 + 1000;
    localparam int STALL_LIMIT    = 20;

    logic        clock;
    logic        rst_i;
    logic        spi_sck_i;
    logic        spi_cs_ni;
    logic        spi_pico_i;
    logic        spi_poci_o;
    logic        spi_stall_o;
    logic [7:0]  model_mem [MODEL_SIZE];
    logic [19:0] written_addrs [$];   // Addresses known to hold data
    logic [19:0] last_addr;
    int          errors;
    int          tests_run;
    int          tests_failed;

    spi_bridge_top #(
        .MEM_ADDR_BITS (MEM_BITS)
    ) dut0 (
        .clock       (clock),
        .rst_i       (rst_i),
        .spi_sck_i   (spi_sck_i),
        .spi_cs_ni   (spi_cs_ni),
        .spi_pico_i  (spi_pico_i),
        .spi_poci_o  (spi_poci_o),
        .spi_stall_o (spi_stall_o)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("ERROR: run exceeded %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [7:0] cmd_byte(input spi_bridge_pkg::spi_op_e op,
                                            input logic [3:0] top);
        return {op, 2'b00, top};
    endfunction

    function automatic logic [7:0] model_read(input logic [19:0] addr);
        return model_mem[addr[MEM_BITS-1:0]];   // Upper bits alias
    endfunction

    task automatic check_value(input string sig, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %02h got %02h", $time, sig, expected, actual);
            errors++;
        end
    endtask

    // Mode 0, MSB first; POCI is sampled just before each rising SCK
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi_pico_i <= tx[i];
            repeat (HALF_SCK - 1) @(posedge clock);
            @(negedge clock);
            rx[i] = spi_poci_o;
            @(posedge clock);
            spi_sck_i <= 1'b1;
            repeat (HALF_SCK) @(posedge clock);
            spi_sck_i <= 1'b0;
        end
    endtask

    task automatic wait_stall();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!spi_stall_o && cycles < STALL_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!spi_stall_o) begin
            $display("ERROR: t=%0t stall did not rise after the command", $time);
            errors++;
        end
        cycles = 0;
        while (spi_stall_o && cycles < STALL_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (spi_stall_o) begin
            $display("ERROR: t=%0t stall stayed high, bus cycle never finished", $time);
            errors++;
        end
        @(posedge clock);
    endtask

    task automatic frame_begin();
        @(posedge clock);
        spi_cs_ni <= 1'b0;
        repeat (3) @(posedge clock);
    endtask

    task automatic frame_finish();
        repeat (3) @(posedge clock);
        spi_cs_ni <= 1'b1;
        repeat (6) @(posedge clock);   // CS high gap between frames
    endtask

    task automatic stall_is_low();
        @(negedge clock);
        check_value("spi_stall_o", 8'h00, {7'b0, spi_stall_o});
        @(posedge clock);
    endtask

    task automatic write_at(input logic [19:0] addr, input logic [7:0] data);
        logic [7:0] rx;
        frame_begin();
        spi_byte(cmd_byte(spi_bridge_pkg::OP_WRITE_AT, addr[19:16]), rx);
        spi_byte(addr[15:8], rx);
        spi_byte(addr[7:0], rx);
        spi_byte(data, rx);
        wait_stall();
        frame_finish();
        model_mem[addr[MEM_BITS-1:0]] = data;
        written_addrs.push_back(addr);
        last_addr = addr;
    endtask

    task automatic read_at(input logic [19:0] addr, output logic [7:0] data);
        logic [7:0] rx;
        frame_begin();
        spi_byte(cmd_byte(spi_bridge_pkg::OP_READ_AT, addr[19:16]), rx);
        spi_byte(addr[15:8], rx);
        spi_byte(addr[7:0], rx);
        wait_stall();
        spi_byte(8'h00, data);   // Dummy byte carries the read data
        frame_finish();
        last_addr = addr;
    endtask

    task automatic read_next(output logic [7:0] data);
        logic [7:0] rx;
        frame_begin();
        spi_byte(cmd_byte(spi_bridge_pkg::OP_READ_NEXT, 4'h0), rx);
        wait_stall();
        spi_byte(8'h00, data);
        frame_finish();
        last_addr = last_addr + 20'd1;   // Wraps at 2^20
    endtask

    task automatic check_read(input logic [19:0] addr);
        logic [7:0] got;
        read_at(addr, got);
        check_value("spi_poci_o", model_read(addr), got);
    endtask

    task automatic test_done(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%-22s ok", name);
        end else begin
            tests_failed++;
            $display("%-22s %0d error(s)", name, errors - err_before);
        end
    endtask

    task automatic test_reset_state();
        int err_before;
        err_before = errors;
        @(negedge clock);
        check_value("spi_stall_o", 8'h00, {7'b0, spi_stall_o});
        check_value("spi_poci_o", 8'h00, {7'b0, spi_poci_o});
        @(posedge clock);
        test_done("reset state", err_before);
    endtask

    task automatic test_write_read();
        int          err_before;
        logic [19:0] addrs [3];
        err_before = errors;
        addrs = '{20'h00000, 20'hFFFFF, 20'h5A3C7};
        foreach (addrs[i]) begin
            write_at(addrs[i], 8'($urandom));
            check_read(addrs[i]);
        end
        test_done("write then read", err_before);
    endtask

    task automatic test_read_next();
        int          err_before;
        logic [19:0] base;
        logic [7:0]  got;
        err_before = errors;
        base = 20'hFFFFD;   // Sequence crosses FFFFF to 00000
        for (int i = 0; i < 6; i++) begin
            write_at(base + 20'(i), 8'($urandom));
        end
        check_read(base);
        repeat (5) begin
            read_next(got);
            check_value("spi_poci_o", model_read(last_addr), got);
        end
        test_done("read_next wrap", err_before);
    endtask

    task automatic test_alias();
        int          err_before;
        logic [19:0] addr;
        logic [7:0]  data;
        logic [7:0]  got;
        err_before = errors;
        addr = 20'h01234;
        data = 8'($urandom);
        write_at(addr, data);
        read_at(addr + 20'h01000, got);
        check_value("spi_poci_o", data, got);
        test_done("address alias", err_before);
    endtask

    task automatic test_abort_reserved();
        int          err_before;
        logic [19:0] addr;
        logic [7:0]  rx;
        err_before = errors;
        addr = 20'h00777;
        write_at(addr, 8'h3C);
        frame_begin();   // Cut after one address byte
        spi_byte(cmd_byte(spi_bridge_pkg::OP_WRITE_AT, addr[19:16]), rx);
        spi_byte(addr[15:8], rx);
        stall_is_low();
        frame_finish();
        check_read(addr);
        frame_begin();
        spi_byte(cmd_byte(spi_bridge_pkg::OP_RESERVED, addr[19:16]), rx);
        spi_byte(addr[15:8], rx);
        spi_byte(addr[7:0], rx);
        spi_byte(8'hA5, rx);
        stall_is_low();
        frame_finish();
        check_read(addr);
        write_at(addr + 20'd1, 8'h96);
        check_read(addr + 20'd1);
        test_done("abort and reserved", err_before);
    endtask

    task automatic test_random_mix();
        int          err_before;
        int          idx;
        logic [31:0] rnd;
        logic [19:0] pick;
        err_before = errors;
        for (int n = 0; n < 40; n++) begin
            rnd = $urandom;
            if (rnd[0] || written_addrs.size() == 0) begin
                write_at(rnd[31:12], 8'($urandom));
            end else begin
                idx  = int'($urandom % written_addrs.size());
                pick = written_addrs[idx];
                check_read({rnd[19:12], pick[11:0]});   // Random alias of a written byte
            end
        end
        test_done("random mix", err_before);
    endtask

    initial begin
        void'($urandom(32'heffcac17));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        last_addr    = '0;
        rst_i      <= 1'b1;
        spi_sck_i  <= 1'b0;
        spi_cs_ni  <= 1'b1;
        spi_pico_i <= 1'b0;
        repeat (8) @(posedge clock);
        rst_i <= 1'b0;
        @(posedge clock);
        test_reset_state();
        test_write_read();
        test_read_next();
        test_alias();
        test_abort_reserved();
        test_random_mix();
        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule
